//--- hdl/csr_regfile.sv
`timescale 1ns/1ps
`include "spi_csr_defines.svh"

module csr_regfile (
    input  logic                   clk,
    input  logic                   reset_i,
    input  spi_csr_pkg::csr_acc_t  csr_acc_i,
    input  spi_csr_pkg::dbg_bus_t  dbgout_i,
    input  spi_csr_pkg::rate_bus_t rate_i,
    output spi_csr_pkg::byte_t     rd_data_o,
    output spi_csr_pkg::vol_bus_t  vol_o,
    output logic                   nkmd_rst_o,
    output spi_csr_pkg::dbg_bus_t  dbgin_o
);
    import spi_csr_pkg::*;

    localparam int vol_bytes = `SPI_CSR_NUM_CH * 4;
    localparam int vol_aw    = $clog2(vol_bytes);
    localparam int dbg_bytes = $bits(dbg_bus_t) / 8;
    localparam int dbg_aw    = $clog2(dbg_bytes);
    localparam int rate_aw   = $clog2(`SPI_CSR_NUM_SPDIF_IN);

    byte_t     vol_q [vol_bytes];
    byte_t     dbgin_q [dbg_bytes];
    byte_t     ctrl_q;
    byte_t     dbgout_byte [dbg_bytes];
    byte_t     rate_byte [`SPI_CSR_NUM_SPDIF_IN];

    csr_addr_t vol_off;
    csr_addr_t dbgin_off;
    csr_addr_t dbgout_off;
    csr_addr_t rate_off;
    logic      hit_vol;
    logic      hit_ctrl;
    logic      hit_dbgin;
    logic      hit_dbgout;
    logic      hit_rate;

    // ************************************************************************
    // address decode, offsets wrap below each base
    // ************************************************************************
    assign vol_off    = csr_acc_i.addr - `SPI_CSR_VOL_BASE;
    assign dbgin_off  = csr_acc_i.addr - `SPI_CSR_DBGIN_BASE;
    assign dbgout_off = csr_acc_i.addr - `SPI_CSR_DBGOUT_BASE;
    assign rate_off   = csr_acc_i.addr - `SPI_CSR_RATE_BASE;

    assign hit_vol    = vol_off < vol_bytes;
    assign hit_ctrl   = csr_acc_i.addr == `SPI_CSR_CTRL_ADDR;
    assign hit_dbgin  = dbgin_off < dbg_bytes;
    assign hit_dbgout = dbgout_off < dbg_bytes;
    assign hit_rate   = rate_off < `SPI_CSR_NUM_SPDIF_IN;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ctrl_q <= 8'h01;   // processor held in reset
            for (int i = 0; i < vol_bytes; i++) begin
                vol_q[i] <= '0;
            end
            for (int i = 0; i < dbg_bytes; i++) begin
                dbgin_q[i] <= '0;
            end
        end else if (csr_acc_i.we) begin
            if (hit_vol) begin
                vol_q[vol_off[vol_aw-1:0]] <= csr_acc_i.wdata;
            end else if (hit_ctrl) begin
                ctrl_q <= csr_acc_i.wdata;
            end else if (hit_dbgin) begin
                dbgin_q[dbgin_off[dbg_aw-1:0]] <= csr_acc_i.wdata;
            end
        end
    end

    // ************************************************************************
    // output packing and read mux
    // ************************************************************************
    for (genvar c = 0; c < `SPI_CSR_NUM_CH; c++) begin : g_vol
        assign vol_o[32*c +: 32] = {vol_q[4*c], vol_q[4*c+1], vol_q[4*c+2], vol_q[4*c+3]};
    end

    for (genvar d = 0; d < dbg_bytes; d++) begin : g_dbg
        assign dbgin_o[8*d +: 8] = dbgin_q[d];
        assign dbgout_byte[d]    = dbgout_i[8*d +: 8];
    end

    for (genvar r = 0; r < `SPI_CSR_NUM_SPDIF_IN; r++) begin : g_rate
        assign rate_byte[r] = {{(8-`SPI_CSR_NUM_RATE){1'b0}},
                               rate_i[`SPI_CSR_NUM_RATE*r +: `SPI_CSR_NUM_RATE]};
    end

    assign nkmd_rst_o = ctrl_q[0];

    always_comb begin
        rd_data_o = '0;   // unmapped
        if (hit_vol) begin
            rd_data_o = vol_q[vol_off[vol_aw-1:0]];
        end else if (hit_ctrl) begin
            rd_data_o = ctrl_q;
        end else if (hit_dbgin) begin
            rd_data_o = dbgin_q[dbgin_off[dbg_aw-1:0]];
        end else if (hit_dbgout) begin
            rd_data_o = dbgout_byte[dbgout_off[dbg_aw-1:0]];
        end else if (hit_rate) begin
            rd_data_o = rate_byte[rate_off[rate_aw-1:0]];
        end
    end

endmodule

//--- hdl/spi_byte_trx.sv
`timescale 1ns/1ps

module spi_byte_trx (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               sck_i,
    input  logic               ss_n_i,
    input  logic               mosi_i,
    input  spi_csr_pkg::byte_t tx_byte_i,
    input  logic               tx_load_i,
    output logic               miso_o,
    output spi_csr_pkg::byte_t rx_byte_o,
    output logic               rx_valid_o,
    output logic               xfer_reset_o
);
    import spi_csr_pkg::*;

    logic [1:0] sck_sync;
    logic [1:0] ss_sync;
    logic [1:0] mosi_sync;
    logic       sck_d;
    logic       sck_rise;
    logic       sck_fall;
    logic [2:0] bit_cnt;
    logic       reload_q;   // byte finished, next falling edge starts the reply
    byte_t      rx_shift;
    byte_t      tx_stage;
    byte_t      tx_shift;

    // ************************************************************************
    // input synchronizers and sck edge detect
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (reset_i) begin
            sck_sync  <= 2'b00;
            ss_sync   <= 2'b11;
            mosi_sync <= 2'b00;
            sck_d     <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[0], sck_i};
            ss_sync   <= {ss_sync[0], ss_n_i};
            mosi_sync <= {mosi_sync[0], mosi_i};
            sck_d     <= sck_sync[1];
        end
    end

    assign sck_rise     = sck_sync[1] & ~sck_d;
    assign sck_fall     = ~sck_sync[1] & sck_d;
    assign xfer_reset_o = ss_sync[1];

    // ************************************************************************
    // bit counter and transmit shifter
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (reset_i || ss_sync[1]) begin
            bit_cnt    <= '0;
            rx_valid_o <= 1'b0;
            reload_q   <= 1'b0;
            tx_shift   <= '0;
        end else begin
            rx_valid_o <= 1'b0;
            if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    rx_valid_o <= 1'b1;
                    reload_q   <= 1'b1;
                end
            end
            if (sck_fall) begin
                if (reload_q) begin
                    tx_shift <= tx_stage;
                    reload_q <= 1'b0;
                end else begin
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
        end
    end

    // receive data path, msb first
    always_ff @(posedge clk) begin
        if (sck_rise) begin
            rx_shift <= {rx_shift[6:0], mosi_sync[1]};
            if (bit_cnt == 3'd7) begin
                rx_byte_o <= {rx_shift[6:0], mosi_sync[1]};
            end
        end
        if (tx_load_i) begin
            tx_stage <= tx_byte_i;   // held until the byte boundary
        end
    end

    assign miso_o = tx_shift[7];

endmodule

//--- hdl/spi_cmd_engine.sv
`timescale 1ns/1ps
`include "spi_csr_defines.svh"

module spi_cmd_engine (
    input  logic                  clk,
    input  logic                  reset_i,
    input  spi_csr_pkg::byte_t    rx_byte_i,
    input  logic                  rx_valid_i,
    input  logic                  xfer_reset_i,
    input  spi_csr_pkg::byte_t    rd_data_i,
    output spi_csr_pkg::byte_t    tx_byte_o,
    output logic                  tx_load_o,
    output spi_csr_pkg::csr_acc_t csr_acc_o,
    output spi_csr_pkg::prom_wr_t prom_wr_o
);
    import spi_csr_pkg::*;

    engine_state_t state_q;
    logic          wr_q;
    prom_addr_t    addr_q;         // register address uses bits 19:8
    word_t         word_q;
    logic [1:0]    offset_q;
    byte_t         reply_q;
    logic          reply_load_q;
    logic          prom_valid_q;
    prom_addr_t    prom_addr_q;

    logic          cmd_wr;
    logic [1:0]    cmd_target;
    logic [3:0]    cmd_nibble;

    // command byte fields
    assign cmd_wr     = rx_byte_i[7];
    assign cmd_target = rx_byte_i[5:4];
    assign cmd_nibble = rx_byte_i[3:0];

    // ************************************************************************
    // transfer state machine
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (reset_i || xfer_reset_i) begin
            state_q      <= s_idle;
            wr_q         <= 1'b0;
            offset_q     <= '0;
            reply_load_q <= 1'b0;
            prom_valid_q <= 1'b0;
        end else begin
            reply_load_q <= 1'b0;
            prom_valid_q <= 1'b0;
            case (state_q)
                s_idle: begin
                    if (rx_valid_i) begin
                        wr_q         <= cmd_wr;
                        offset_q     <= '0;
                        reply_load_q <= 1'b1;
                        if (cmd_target == 2'd0) begin
                            state_q <= s_csr_addr;
                        end else if (cmd_target == 2'd1) begin
                            state_q <= s_prom_mid;
                        end
                    end
                end
                s_csr_addr: begin
                    if (rx_valid_i) begin
                        reply_load_q <= 1'b1;
                        state_q      <= s_csr_data;
                    end
                end
                s_csr_data: begin
                    if (rx_valid_i) begin
                        state_q <= s_csr_respond;   // write lands this edge
                    end
                end
                s_csr_respond: begin
                    state_q <= s_csr_data;
                end
                s_prom_mid: begin
                    if (rx_valid_i) begin
                        reply_load_q <= 1'b1;
                        state_q      <= s_prom_low;
                    end
                end
                s_prom_low: begin
                    if (rx_valid_i) begin
                        reply_load_q <= 1'b1;
                        state_q      <= s_prom_data;
                    end
                end
                s_prom_data: begin
                    if (rx_valid_i) begin
                        reply_load_q <= 1'b1;
                        offset_q     <= offset_q + 2'd1;
                        if (wr_q && offset_q == 2'd3) begin
                            state_q <= s_prom_write;
                        end
                    end
                end
                s_prom_write: begin
                    prom_valid_q <= 1'b1;
                    state_q      <= s_prom_data;
                end
                default: begin
                    state_q <= s_idle;
                end
            endcase
        end
    end

    // ************************************************************************
    // address, word assembly and reply bytes
    // ************************************************************************
    always_ff @(posedge clk) begin
        case (state_q)
            s_idle: begin
                if (rx_valid_i) begin
                    addr_q  <= {cmd_nibble, 16'h0000};
                    reply_q <= `SPI_CSR_ACK_CMD;   // also for unknown targets
                end
            end
            s_csr_addr: begin
                if (rx_valid_i) begin
                    addr_q[15:8] <= rx_byte_i;
                    reply_q      <= `SPI_CSR_ACK_CSR_ADDR;
                end
            end
            s_csr_respond: begin
                addr_q[19:8] <= addr_q[19:8] + 12'd1;
            end
            s_prom_mid: begin
                if (rx_valid_i) begin
                    addr_q[15:8] <= rx_byte_i;
                    reply_q      <= `SPI_CSR_ACK_PROM_MID;
                end
            end
            s_prom_low: begin
                if (rx_valid_i) begin
                    addr_q[7:0] <= rx_byte_i;
                    reply_q     <= `SPI_CSR_ACK_PROM_LOW;
                end
            end
            s_prom_data: begin
                if (rx_valid_i) begin
                    word_q  <= {word_q[23:0], rx_byte_i};   // first byte ends up msb
                    reply_q <= `SPI_CSR_ACK_PROM_DATA | {6'b000000, offset_q};
                end
            end
            s_prom_write: begin
                prom_addr_q <= addr_q;
                addr_q      <= addr_q + 20'd1;
            end
            default: begin
            end
        endcase
    end

    // register read reply goes straight out of the respond state
    assign tx_load_o = reply_load_q || (state_q == s_csr_respond);
    assign tx_byte_o = (state_q == s_csr_respond) ? rd_data_i : reply_q;

    assign csr_acc_o.we    = rx_valid_i && wr_q && (state_q == s_csr_data);
    assign csr_acc_o.addr  = addr_q[19:8];
    assign csr_acc_o.wdata = rx_byte_i;

    assign prom_wr_o.valid = prom_valid_q;
    assign prom_wr_o.addr  = prom_addr_q;
    assign prom_wr_o.data  = word_q;   // stable until the next data byte

endmodule

//--- hdl/spi_csr_pkg.sv
`include "spi_csr_defines.svh"

package spi_csr_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [11:0] csr_addr_t;     // register byte address
    typedef logic [19:0] prom_addr_t;    // program memory word address
    typedef logic [31:0] word_t;

    typedef logic [`SPI_CSR_NUM_CH*32-1:0]                   vol_bus_t;
    typedef logic [127:0]                                    dbg_bus_t;
    typedef logic [`SPI_CSR_NUM_SPDIF_IN*`SPI_CSR_NUM_RATE-1:0] rate_bus_t;

    typedef enum logic [2:0] {
        s_idle,
        s_csr_addr,
        s_csr_data,
        s_csr_respond,
        s_prom_mid,
        s_prom_low,
        s_prom_data,
        s_prom_write
    } engine_state_t;

    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        byte_t     wdata;
    } csr_acc_t;

    typedef struct packed {
        logic       valid;
        prom_addr_t addr;
        word_t      data;
    } prom_wr_t;

endpackage

//--- hdl/spi_csr_top.sv
`timescale 1ns/1ps

module spi_csr_top (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   sck_i,
    input  logic                   ss_n_i,
    input  logic                   mosi_i,
    output logic                   miso_o,
    output spi_csr_pkg::vol_bus_t  vol_o,
    output logic                   nkmd_rst_o,
    input  spi_csr_pkg::dbg_bus_t  dbgout_i,
    output spi_csr_pkg::dbg_bus_t  dbgin_o,
    input  spi_csr_pkg::rate_bus_t rate_i,
    output spi_csr_pkg::prom_wr_t  prom_wr_o
);
    import spi_csr_pkg::*;

    byte_t    rx_byte;
    logic     rx_valid;
    byte_t    tx_byte;
    logic     tx_load;
    logic     xfer_reset;
    csr_acc_t csr_acc;
    byte_t    rd_data;

    spi_byte_trx u_trx (
        .clk(clk), .reset_i(reset_i),
        .sck_i(sck_i), .ss_n_i(ss_n_i), .mosi_i(mosi_i), .miso_o(miso_o),
        .tx_byte_i(tx_byte), .tx_load_i(tx_load),
        .rx_byte_o(rx_byte), .rx_valid_o(rx_valid),
        .xfer_reset_o(xfer_reset)
    );

    spi_cmd_engine u_engine (
        .clk(clk), .reset_i(reset_i),
        .rx_byte_i(rx_byte), .rx_valid_i(rx_valid), .xfer_reset_i(xfer_reset),
        .rd_data_i(rd_data),
        .tx_byte_o(tx_byte), .tx_load_o(tx_load),
        .csr_acc_o(csr_acc), .prom_wr_o(prom_wr_o)
    );

    csr_regfile u_regfile (
        .clk(clk), .reset_i(reset_i),
        .csr_acc_i(csr_acc), .rd_data_o(rd_data),
        .vol_o(vol_o), .nkmd_rst_o(nkmd_rst_o),
        .dbgout_i(dbgout_i), .dbgin_o(dbgin_o), .rate_i(rate_i)
    );

endmodule

//--- include/spi_csr_defines.svh
`ifndef SPI_CSR_DEFINES_SVH
`define SPI_CSR_DEFINES_SVH

// board configuration
`define SPI_CSR_NUM_CH          8
`define SPI_CSR_NUM_SPDIF_IN    3
`define SPI_CSR_NUM_RATE        5

// register map, byte addresses
`define SPI_CSR_VOL_BASE        12'h000
`define SPI_CSR_CTRL_ADDR       12'h020
`define SPI_CSR_DBGIN_BASE      12'h040
`define SPI_CSR_DBGOUT_BASE     12'h050
`define SPI_CSR_RATE_BASE       12'h060

// reply bytes shifted back to the host
`define SPI_CSR_ACK_CMD         8'hCC
`define SPI_CSR_ACK_CSR_ADDR    8'hAD
`define SPI_CSR_ACK_PROM_MID    8'hA0
`define SPI_CSR_ACK_PROM_LOW    8'hA1
`define SPI_CSR_ACK_PROM_DATA   8'hD0   // low two bits carry the byte position

`endif

//--- run_sim.sh
#!/bin/sh
# build and run the SPI register bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f spi_csr_top.f \
    --top-module spi_csr_tb -Mdir obj_dir -o spi_csr_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/spi_csr_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1

//--- sim/spi_csr_props.sv
`timescale 1ns/1ps

module spi_csr_props (
    input logic                          clk,
    input logic                          reset_i,
    input logic                          xfer_reset_i,
    input logic                          rx_valid_i,
    input logic                          tx_load_i,
    input spi_csr_pkg::csr_acc_t         csr_acc_i,
    input spi_csr_pkg::prom_wr_t         prom_wr_i,
    input spi_csr_pkg::engine_state_t    state_i
);
    import spi_csr_pkg::*;

    // every received byte has its reply staged on the next cycle
    a_reply_staged: assert property (@(posedge clk) disable iff (reset_i || xfer_reset_i)
        rx_valid_i |=> tx_load_i)
        else $error("tx_load missing one cycle after rx_valid");

    a_we_pulse: assert property (@(posedge clk) disable iff (reset_i)
        csr_acc_i.we |=> !csr_acc_i.we)
        else $error("register write enable longer than one cycle");

    a_prom_pulse: assert property (@(posedge clk) disable iff (reset_i)
        prom_wr_i.valid |=> !prom_wr_i.valid)
        else $error("prom_wr valid longer than one cycle");

    // pulse comes out of the write state two cycles after the last data byte
    a_prom_src: assert property (@(posedge clk) disable iff (reset_i)
        prom_wr_i.valid |-> $past(state_i == s_prom_write) && $past(rx_valid_i, 2))
        else $error("prom_wr valid without a preceding prom_write state and data byte");

endmodule

bind spi_cmd_engine spi_csr_props u_props (
    .clk(clk), .reset_i(reset_i), .xfer_reset_i(xfer_reset_i),
    .rx_valid_i(rx_valid_i), .tx_load_i(tx_load_o),
    .csr_acc_i(csr_acc_o), .prom_wr_i(prom_wr_o), .state_i(state_q)
);

//--- sim/spi_csr_tb.sv
`timescale 1ns/1ps
`include "spi_csr_defines.svh"

module spi_csr_tb;
    import spi_csr_pkg::*;

    logic      clk = 1'b0;
    logic      reset_i;
    logic      sck;
    logic      ss_n;
    logic      mosi;
    logic      miso;
    logic      nkmd_rst;
    vol_bus_t  vol;
    dbg_bus_t  dbgout;
    dbg_bus_t  dbgin;
    rate_bus_t rate;
    prom_wr_t  prom_wr;

    integer    seed = 36886;
    int        err_count = 0;
    int        n_tests = 0;
    int        n_failed = 0;
    byte_t     txq[$];
    byte_t     rxq[$];      // rxq[i] is the reply to txq[i]
    prom_wr_t  prom_q[$];
    byte_t     vol_exp[8];  // volume bytes at 0x000..0x007

    spi_csr_top dut (
        .clk(clk), .reset_i(reset_i),
        .sck_i(sck), .ss_n_i(ss_n), .mosi_i(mosi), .miso_o(miso),
        .vol_o(vol), .nkmd_rst_o(nkmd_rst),
        .dbgout_i(dbgout), .dbgin_o(dbgin), .rate_i(rate),
        .prom_wr_o(prom_wr)
    );

    always #4 clk = ~clk;

    // program memory write monitor, sampled away from the active edge
    always @(negedge clk) begin
        if (!reset_i && prom_wr.valid) begin
            prom_q.push_back(prom_wr);
        end
    end

    // ************************************************************************
    // SPI host model
    // ************************************************************************
    task automatic wait_clks(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_prom(input int n);
        int cnt;
        cnt = 0;
        while (prom_q.size() < n && cnt < 200) begin
            @(posedge clk);
            cnt++;
        end
        if (prom_q.size() < n) begin
            $display("ERROR: program memory write pulse missing after 200 cycles");
            err_count++;
        end
    endtask

    // mode 0, msb first; miso read just before each rising sck
    task automatic spi_byte(input byte_t tx, output byte_t rx);
        for (int b = 7; b >= 0; b--) begin
            mosi <= tx[b];
            wait_clks(4);
            @(negedge clk);
            rx[b] = miso;
            @(posedge clk);
            sck <= 1'b1;
            wait_clks(5);
            sck <= 1'b0;
        end
    endtask

    task automatic spi_xfer();
        byte_t r;
        rxq = {};
        ss_n <= 1'b0;
        wait_clks(5);
        foreach (txq[i]) begin
            spi_byte(txq[i], r);
            if (i > 0) begin
                rxq.push_back(r);   // reply to the previous byte
            end
        end
        wait_clks(5);
        ss_n <= 1'b1;
        wait_clks(10);
    endtask

    task automatic pad_bytes(input int n);
        for (int i = 0; i < n; i++) begin
            txq.push_back(8'h00);
        end
    endtask

    // ************************************************************************
    // checking and bookkeeping
    // ************************************************************************
    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_reply(input string tn, input int idx, input byte_t exp);
        check_eq($sformatf("%s reply %0d", tn, idx), 32'(exp), 32'(rxq[idx]));
    endtask

    task automatic end_test(input string tn, input int errs_before);
        n_tests++;
        if (err_count == errs_before) begin
            $display("test %s passed", tn);
        end else begin
            n_failed++;
            $display("test %s failed with %0d errors", tn, err_count - errs_before);
        end
    endtask

    // ************************************************************************
    // tests
    // ************************************************************************
    task automatic test_vol_burst();
        int e0;
        e0 = err_count;
        txq = {8'h80, 8'h00};
        for (int i = 0; i < 8; i++) begin
            vol_exp[i] = 8'($random(seed));
            txq.push_back(vol_exp[i]);
        end
        spi_xfer();
        check_reply("vol_wr", 0, `SPI_CSR_ACK_CMD);
        check_reply("vol_wr", 1, `SPI_CSR_ACK_CSR_ADDR);
        for (int i = 0; i < 7; i++) begin
            check_reply("vol_wr", i + 2, vol_exp[i]);   // value after the write
        end
        txq = {8'h00, 8'h00};
        pad_bytes(9);
        spi_xfer();
        check_reply("vol_rd", 0, `SPI_CSR_ACK_CMD);
        check_reply("vol_rd", 1, `SPI_CSR_ACK_CSR_ADDR);
        for (int i = 0; i < 8; i++) begin
            check_reply("vol_rd", i + 2, vol_exp[i]);
        end
        check_eq("vol ch0", {vol_exp[0], vol_exp[1], vol_exp[2], vol_exp[3]}, vol[31:0]);
        check_eq("vol ch1", {vol_exp[4], vol_exp[5], vol_exp[6], vol_exp[7]}, vol[63:32]);
        end_test("vol_burst", e0);
    endtask

    task automatic test_read_only();
        int        e0;
        dbg_bus_t  dv;
        rate_bus_t rv;
        e0 = err_count;
        dv = {$random(seed), $random(seed), $random(seed), $random(seed)};
        rv = 15'($random(seed));
        dbgout <= dv;
        rate   <= rv;
        @(posedge clk);
        txq = {8'h00, 8'h50};
        pad_bytes(17);
        spi_xfer();
        for (int i = 0; i < 16; i++) begin
            check_reply("dbgout", i + 2, dv[8*i +: 8]);
        end
        txq = {8'h00, 8'h60};
        pad_bytes(4);
        spi_xfer();
        for (int i = 0; i < 3; i++) begin
            check_reply("rate", i + 2, {3'b000, rv[5*i +: 5]});
        end
        txq = {8'h80, 8'h50, ~dv[7:0], 8'h00};
        spi_xfer();
        check_reply("dbgout write", 2, dv[7:0]);   // write is ignored
        end_test("read_only", e0);
    endtask

    task automatic test_ctrl_dbgin();
        int       e0;
        dbg_bus_t dexp;
        e0 = err_count;
        check_eq("nkmd_rst after reset", 32'd1, 32'(nkmd_rst));
        txq = {8'h80, 8'h20, 8'h00};
        spi_xfer();
        check_eq("nkmd_rst cleared", 32'd0, 32'(nkmd_rst));
        txq = {8'h80, 8'h40};
        for (int i = 0; i < 16; i++) begin
            dexp[8*i +: 8] = 8'($random(seed));
            txq.push_back(dexp[8*i +: 8]);
        end
        spi_xfer();
        for (int w = 0; w < 4; w++) begin
            check_eq($sformatf("dbgin word %0d", w), dexp[32*w +: 32], dbgin[32*w +: 32]);
        end
        end_test("ctrl_dbgin", e0);
    endtask

    task automatic test_prom_write();
        int    e0;
        byte_t d[8];
        e0 = err_count;
        prom_q = {};
        txq = {8'h92, 8'h34, 8'h56};
        for (int i = 0; i < 8; i++) begin
            d[i] = 8'($random(seed));
            txq.push_back(d[i]);
        end
        pad_bytes(1);
        spi_xfer();
        check_reply("prom_wr", 0, `SPI_CSR_ACK_CMD);
        check_reply("prom_wr", 1, `SPI_CSR_ACK_PROM_MID);
        check_reply("prom_wr", 2, `SPI_CSR_ACK_PROM_LOW);
        for (int i = 0; i < 8; i++) begin
            check_reply("prom_wr", i + 3, `SPI_CSR_ACK_PROM_DATA + 8'(i % 4));
        end
        wait_prom(2);
        check_eq("prom_wr pulses", 32'd2, 32'(prom_q.size()));
        check_eq("prom_wr addr 0", 32'h23456, 32'(prom_q[0].addr));
        check_eq("prom_wr data 0", {d[0], d[1], d[2], d[3]}, prom_q[0].data);
        check_eq("prom_wr addr 1", 32'h23457, 32'(prom_q[1].addr));
        check_eq("prom_wr data 1", {d[4], d[5], d[6], d[7]}, prom_q[1].data);
        end_test("prom_write", e0);
    endtask

    task automatic test_prom_read_abort();
        int    e0;
        byte_t d[4];
        e0 = err_count;
        prom_q = {};
        txq = {8'h12, 8'h34, 8'h56};
        pad_bytes(5);
        spi_xfer();
        check_reply("prom_rd", 0, `SPI_CSR_ACK_CMD);
        check_reply("prom_rd", 1, `SPI_CSR_ACK_PROM_MID);
        check_reply("prom_rd", 2, `SPI_CSR_ACK_PROM_LOW);
        for (int i = 0; i < 4; i++) begin
            check_reply("prom_rd", i + 3, `SPI_CSR_ACK_PROM_DATA + 8'(i));
        end
        // write aborted after two data bytes
        txq = {8'h92, 8'h34, 8'h56, 8'h11, 8'h22};
        spi_xfer();
        check_eq("prom no pulse", 32'd0, 32'(prom_q.size()));
        txq = {8'h00, 8'h00};
        pad_bytes(5);
        spi_xfer();
        for (int i = 0; i < 4; i++) begin
            check_reply("abort csr_rd", i + 2, vol_exp[i]);
        end
        txq = {8'h92, 8'h00, 8'h10};
        for (int i = 0; i < 4; i++) begin
            d[i] = 8'($random(seed));
            txq.push_back(d[i]);
        end
        spi_xfer();
        wait_prom(1);
        check_eq("abort pulses", 32'd1, 32'(prom_q.size()));
        check_eq("abort addr", 32'h20010, 32'(prom_q[0].addr));
        check_eq("abort data", {d[0], d[1], d[2], d[3]}, prom_q[0].data);
        end_test("prom_read_abort", e0);
    endtask

    initial begin
        reset_i <= 1'b1;
        sck     <= 1'b0;
        ss_n    <= 1'b1;
        mosi    <= 1'b0;
        dbgout  <= '0;
        rate    <= '0;
        wait_clks(3);
        reset_i <= 1'b0;
        wait_clks(2);
        test_vol_burst();
        test_read_only();
        test_ctrl_dbgin();
        test_prom_write();
        test_prom_read_abort();
        $display("tests %0d, failed %0d, mismatches %0d", n_tests, n_failed, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- spi_csr_top.f
+incdir+include
hdl/spi_csr_pkg.sv
hdl/spi_byte_trx.sv
hdl/spi_cmd_engine.sv
hdl/csr_regfile.sv
hdl/spi_csr_top.sv
sim/spi_csr_props.sv
sim/spi_csr_tb.sv
